//--- source/dcachePkg.sv
`default_nettype none

package dcachePkg;

    // address geometry
    localparam int addrWidth = 12;
    localparam int wordBytes = 4;
    localparam int blockWords = 4;
    localparam int blockBytes = 16;
    localparam int offsetWidth = 4;
    localparam int indexWidth = 4;
    localparam int tagWidth = 4;

    // backing memory cycles per access
    localparam int memLatency = 4;

    // derived sizes
    localparam int wordWidth = wordBytes * 8;
    localparam int blockWidth = blockBytes * 8;
    localparam int byteSelWidth = $clog2(wordBytes);
    localparam int wordSelWidth = $clog2(blockWords);
    localparam int blockAddrWidth = tagWidth + indexWidth;
    localparam int lineCount = 1 << indexWidth;
    localparam int blockCount = 1 << blockAddrWidth;
    localparam int latencyWidth = $clog2(memLatency + 1);

    typedef logic [addrWidth-1:0] byteAddr;
    typedef logic [blockAddrWidth-1:0] blockAddr;
    typedef logic [indexWidth-1:0] lineIndex;
    typedef logic [tagWidth-1:0] lineTag;
    typedef logic [wordWidth-1:0] dataWord;
    typedef logic [wordBytes-1:0] byteMask;
    typedef logic [blockWidth-1:0] blockData;
    typedef logic [blockBytes-1:0] blockMask;
    typedef logic [latencyWidth-1:0] latencyCount;

    // count value of the response cycle
    localparam latencyCount lastCount = latencyCount'(memLatency);

    typedef enum logic [1:0] {
        idle,
        writeBack,
        memRead,
        fill
    } missState;

    typedef struct packed {
        logic read;
        logic write;
        byteAddr addr;
        byteMask byteSelect;
        dataWord writeData;
    } cacheRequest;

    typedef struct packed {
        logic readEnable;
        logic writeEnable;
        blockAddr address;
        blockData writeBlock;
    } memRequest;

    typedef struct packed {
        logic readReady;
        logic writeDone;
        blockData readBlock;
    } memResponse;

    // lookup result for the index of the current address
    typedef struct packed {
        logic hit;
        logic dirty;
        lineTag victimTag;
        blockData block;
    } lineStatus;

endpackage

`default_nettype wire

//--- source/dcacheArray.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheArray (
    input  wire                      clock,
    input  wire                      reset,

    // lookup
    input  wire dcachePkg::lineIndex lookupIndex,
    input  wire dcachePkg::lineTag   lookupTag,
    output dcachePkg::lineStatus     status,

    // byte-enabled word write on a hit
    input  wire                      wordWrite,
    input  wire dcachePkg::blockMask writeMask,
    input  wire dcachePkg::blockData writeBlock,

    // whole block fill after a miss
    input  wire                      fillEnable,
    input  wire dcachePkg::blockData fillBlock
);

    // per-line state
    logic [dcachePkg::lineCount-1:0] valid;
    logic [dcachePkg::lineCount-1:0] dirty;

    // tag and data storage
    dcachePkg::lineTag tags [dcachePkg::lineCount];
    dcachePkg::blockData blocks [dcachePkg::lineCount];

    dcachePkg::blockData mergedBlock;

    // replace only the bytes selected by the mask
    function automatic dcachePkg::blockData mergeBytes(
        input dcachePkg::blockData oldBlock,
        input dcachePkg::blockData newBlock,
        input dcachePkg::blockMask mask
    );
        dcachePkg::blockData merged;
        merged = oldBlock;
        for (int b = 0; b < dcachePkg::blockBytes; b++) begin
            if (mask[b]) begin
                merged[b*8 +: 8] = newBlock[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    // combinational lookup
    always_comb begin
        status.hit = valid[lookupIndex] && (tags[lookupIndex] == lookupTag);
        // an invalid line never needs a writeback
        status.dirty = valid[lookupIndex] && dirty[lookupIndex];
        status.victimTag = tags[lookupIndex];
        status.block = blocks[lookupIndex];
    end

    assign mergedBlock = mergeBytes(status.block, writeBlock, writeMask);

    // valid and dirty bits
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            valid <= '0;
            dirty <= '0;
        end else if (fillEnable) begin
            valid[lookupIndex] <= 1'b1;
            dirty[lookupIndex] <= 1'b0;
        end else if (wordWrite) begin
            dirty[lookupIndex] <= 1'b1;
        end
    end

    // tags and block data
    always_ff @(posedge clock) begin
        if (fillEnable) begin
            tags[lookupIndex] <= lookupTag;
            blocks[lookupIndex] <= fillBlock;
        end else if (wordWrite) begin
            blocks[lookupIndex] <= mergedBlock;
        end
    end

endmodule

`default_nettype wire

//--- source/blockMemory.sv
`timescale 1ns/1ps
`default_nettype none

module blockMemory (
    input  wire                       clock,
    input  wire                       reset,
    input  wire dcachePkg::memRequest memReq,
    output dcachePkg::memResponse     memResp
);

    // one entry per block address
    dcachePkg::blockData storage [dcachePkg::blockCount];

    dcachePkg::latencyCount count;
    dcachePkg::blockData readBlockReg;

    logic busy;
    logic done;

    // contents start out as zero
    initial begin
        for (int i = 0; i < dcachePkg::blockCount; i++) begin
            storage[i] = '0;
        end
    end

    assign busy = memReq.readEnable || memReq.writeEnable;

    // last cycle of an access
    assign done = busy && (count == dcachePkg::lastCount);

    assign memResp.readReady = memReq.readEnable && done;
    assign memResp.writeDone = memReq.writeEnable && done;
    assign memResp.readBlock = readBlockReg;

    // latency counter, counts from the first enable cycle
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            count <= '0;
        end else if (!busy || done) begin
            // ready for the next access
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // address is held, so the data settles before readReady
    always_ff @(posedge clock) begin
        if (memReq.readEnable) begin
            readBlockReg <= storage[memReq.address];
        end
    end

    // write lands on the writeDone cycle
    always_ff @(posedge clock) begin
        if (memResp.writeDone) begin
            storage[memReq.address] <= memReq.writeBlock;
        end
    end

endmodule

`default_nettype wire

//--- source/dcacheController.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheController (
    input  wire                         clock,
    input  wire                         reset,

    // pipeline side
    input  wire dcachePkg::cacheRequest request,
    output logic                        stall,
    output dcachePkg::dataWord          readData,

    // array lookup
    output dcachePkg::lineIndex         lookupIndex,
    output dcachePkg::lineTag           lookupTag,
    input  wire dcachePkg::lineStatus   status,

    // array word write
    output logic                        wordWrite,
    output dcachePkg::blockMask         writeMask,
    output dcachePkg::blockData         writeBlock,

    // array fill
    output logic                        fillEnable,
    output dcachePkg::blockData         fillBlock,

    // backing memory
    output dcachePkg::memRequest        memReq,
    input  wire dcachePkg::memResponse  memResp
);

    // fields of the held request address
    dcachePkg::lineTag reqTag;
    dcachePkg::lineIndex reqIndex;
    logic [dcachePkg::wordSelWidth-1:0] wordSel;

    logic reqValid;
    logic writeHit;
    logic miss;

    dcachePkg::missState state;
    dcachePkg::missState nextState;

    assign reqTag = request.addr[dcachePkg::addrWidth-1 -: dcachePkg::tagWidth];
    assign reqIndex = request.addr[dcachePkg::offsetWidth +: dcachePkg::indexWidth];
    assign wordSel = request.addr[dcachePkg::byteSelWidth +: dcachePkg::wordSelWidth];

    // exactly one of read and write makes a request
    assign reqValid = request.read ^ request.write;
    assign writeHit = request.write && !request.read && status.hit;
    assign miss = reqValid && !status.hit;

    assign lookupIndex = reqIndex;
    assign lookupTag = reqTag;

    // addressed word out of the looked-up block
    assign readData = status.block[wordSel * dcachePkg::wordWidth +: dcachePkg::wordWidth];

    // held while a miss is pending or being served
    assign stall = (state != dcachePkg::idle) || miss;

    assign wordWrite = writeHit && !stall;
    assign fillEnable = (state == dcachePkg::fill);

    // word and byte mask moved into their lane of the block
    always_comb begin
        writeMask = '0;
        writeBlock = '0;
        writeMask[wordSel * dcachePkg::wordBytes +: dcachePkg::wordBytes] = request.byteSelect;
        writeBlock[wordSel * dcachePkg::wordWidth +: dcachePkg::wordWidth] = request.writeData;
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= dcachePkg::idle;
        end else begin
            state <= nextState;
        end
    end

    // miss sequencing
    always_comb begin
        nextState = state;
        case (state)
            dcachePkg::idle: begin
                if (miss) begin
                    if (status.dirty) begin
                        nextState = dcachePkg::writeBack;
                    end else begin
                        nextState = dcachePkg::memRead;
                    end
                end
            end
            dcachePkg::writeBack: begin
                if (memResp.writeDone) begin
                    nextState = dcachePkg::memRead;
                end
            end
            dcachePkg::memRead: begin
                if (memResp.readReady) begin
                    nextState = dcachePkg::fill;
                end
            end
            dcachePkg::fill: begin
                // the held request hits on return to idle
                nextState = dcachePkg::idle;
            end
            default: begin
                nextState = dcachePkg::idle;
            end
        endcase
    end

    // memory request, held for the whole state
    always_comb begin
        memReq = '0;
        memReq.writeBlock = status.block;
        memReq.address = {reqTag, reqIndex};
        if (state == dcachePkg::writeBack) begin
            // victim goes back to its own block address
            memReq.writeEnable = 1'b1;
            memReq.address = {status.victimTag, reqIndex};
        end
        if (state == dcachePkg::memRead) begin
            memReq.readEnable = 1'b1;
        end
    end

    // fetched block kept for the fill cycle
    always_ff @(posedge clock) begin
        if (state == dcachePkg::memRead && memResp.readReady) begin
            fillBlock <= memResp.readBlock;
        end
    end

endmodule

`default_nettype wire

//--- source/dataCache.sv
`timescale 1ns/1ps
`default_nettype none

module dataCache (
    input  wire                         clock,
    input  wire                         reset,
    input  wire dcachePkg::cacheRequest request,
    output logic                        stall,
    output dcachePkg::dataWord          readData
);

    // controller to array
    dcachePkg::lineIndex lookupIndex;
    dcachePkg::lineTag lookupTag;
    dcachePkg::lineStatus status;
    logic wordWrite;
    dcachePkg::blockMask writeMask;
    dcachePkg::blockData writeBlock;
    logic fillEnable;
    dcachePkg::blockData fillBlock;

    // controller to memory
    dcachePkg::memRequest memReq;
    dcachePkg::memResponse memResp;

    dcacheController controller (
        .clock       (clock),
        .reset       (reset),
        .request     (request),
        .stall       (stall),
        .readData    (readData),
        .lookupIndex (lookupIndex),
        .lookupTag   (lookupTag),
        .status      (status),
        .wordWrite   (wordWrite),
        .writeMask   (writeMask),
        .writeBlock  (writeBlock),
        .fillEnable  (fillEnable),
        .fillBlock   (fillBlock),
        .memReq      (memReq),
        .memResp     (memResp)
    );

    dcacheArray array (
        .clock       (clock),
        .reset       (reset),
        .lookupIndex (lookupIndex),
        .lookupTag   (lookupTag),
        .status      (status),
        .wordWrite   (wordWrite),
        .writeMask   (writeMask),
        .writeBlock  (writeBlock),
        .fillEnable  (fillEnable),
        .fillBlock   (fillBlock)
    );

    blockMemory memory (
        .clock   (clock),
        .reset   (reset),
        .memReq  (memReq),
        .memResp (memResp)
    );

endmodule

`default_nettype wire

//--- test/cacheModel.svh
`ifndef CACHE_MODEL_SVH
`define CACHE_MODEL_SVH

// bytes as the pipeline sees them, indexed by byte address
logic [7:0] modelBytes [1 << dcachePkg::addrWidth];

// backing memory starts out zeroed
function automatic void clearModel();
    modelBytes = '{default: 8'h00};
endfunction

// first byte of the word holding addr
function automatic dcachePkg::byteAddr wordBase(input dcachePkg::byteAddr addr);
    return {addr[dcachePkg::addrWidth-1:dcachePkg::byteSelWidth],
            {dcachePkg::byteSelWidth{1'b0}}};
endfunction

// whole word, lowest address in the low byte
function automatic dcachePkg::dataWord modelRead(input dcachePkg::byteAddr addr);
    dcachePkg::dataWord word;
    dcachePkg::byteAddr base;
    base = wordBase(addr);
    for (int b = 0; b < dcachePkg::wordBytes; b++) begin
        word[b*8 +: 8] = modelBytes[base + dcachePkg::byteAddr'(b)];
    end
    return word;
endfunction

// only the bytes with a mask bit change
function automatic void modelWrite(input dcachePkg::byteAddr addr,
                                   input dcachePkg::byteMask mask,
                                   input dcachePkg::dataWord data);
    dcachePkg::byteAddr base;
    base = wordBase(addr);
    for (int b = 0; b < dcachePkg::wordBytes; b++) begin
        if (mask[b]) begin
            modelBytes[base + dcachePkg::byteAddr'(b)] = data[b*8 +: 8];
        end
    end
endfunction

`endif

//--- test/dataCacheTb.sv
`timescale 1ns/1ps
`default_nettype none

module dataCacheTb;

    // 2+3+5+3+300+3 requests over all tests
    localparam int randomCount = 300;
    localparam int totalRequests = 16 + randomCount;
    localparam int cycleLimit = totalRequests * (2 * (dcachePkg::memLatency + 1) + 3) + 200;

    logic clock;
    logic reset;
    dcachePkg::cacheRequest request;
    logic stall;
    dcachePkg::dataWord readData;

    integer seed;
    int errors;
    int checks;
    int testCount;
    int cycles;

    `include "cacheModel.svh"

    dataCache uut (
        .clock    (clock),
        .reset    (reset),
        .request  (request),
        .stall    (stall),
        .readData (readData)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // run limit
    initial cycles = 0;
    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("timeout: no result after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    task automatic checkWord(input dcachePkg::dataWord got, input dcachePkg::dataWord expected,
                             input string what);
        checks++;
        if (got !== expected) begin
            $display("Fail at %0t: %s got %h, expected %h", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic checkStall(input bit got, input bit expected, input string what);
        checks++;
        if (got !== expected) begin
            $display("Fail at %0t: %s stall %0b, expected %0b", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic dropRequest();
        request = '0;
    endtask

    // one request held until stall is low, called 2 ns after a rising edge
    task automatic access(input bit isWrite, input dcachePkg::byteAddr addr,
                          input dcachePkg::byteMask mask, input dcachePkg::dataWord data,
                          output bit firstStall);
        bit waiting;
        bit first;
        waiting = 1'b1;
        first = 1'b1;
        request.read = !isWrite;
        request.write = isWrite;
        request.addr = addr;
        request.byteSelect = mask;
        request.writeData = data;
        while (waiting) begin
            @(negedge clock);
            if (first) begin
                firstStall = stall;
            end
            first = 1'b0;
            if (!stall) begin
                waiting = 1'b0;
                if (!isWrite) begin
                    checkWord(readData, modelRead(addr), "read data");
                end
            end
            @(posedge clock);
            #2;
        end
        // write took effect at that edge
        if (isWrite) begin
            modelWrite(addr, mask, data);
        end
        dropRequest();
    endtask

    task automatic reportTest(input string name, input int mark);
        testCount++;
        $display("%s: %0d errors", name, errors - mark);
    endtask

    initial begin
        bit firstStall;
        int mark;
        logic [31:0] r;
        dcachePkg::dataWord data;
        seed = 23328;
        errors = 0;
        checks = 0;
        testCount = 0;
        reset = 1'b0;
        dropRequest();
        clearModel();
        repeat (4) @(posedge clock);
        #2;
        reset = 1'b1;

        mark = errors;
        @(negedge clock);
        checkStall(stall, 1'b0, "idle after reset");
        @(posedge clock);
        #2;
        access(1'b0, 12'h000, 4'h0, '0, firstStall);
        checkStall(firstStall, 1'b1, "cold read");
        access(1'b0, 12'h7f4, 4'h0, '0, firstStall);
        reportTest("reset and cold read", mark);

        mark = errors;
        access(1'b1, 12'h124, 4'hf, 32'hcafef00d, firstStall);
        access(1'b0, 12'h124, 4'h0, '0, firstStall);
        access(1'b0, 12'h124, 4'h0, '0, firstStall);
        checkStall(firstStall, 1'b0, "repeated read");
        reportTest("write then read", mark);

        mark = errors;
        access(1'b1, 12'h238, 4'hf, 32'h11223344, firstStall);
        access(1'b1, 12'h238, 4'b0101, 32'haabbccdd, firstStall);
        access(1'b0, 12'h238, 4'h0, '0, firstStall);
        access(1'b1, 12'h23a, 4'b1000, 32'h99eeff00, firstStall);
        access(1'b0, 12'h238, 4'h0, '0, firstStall);
        reportTest("byte masks", mark);

        // same index 5, tags 3 and 7
        mark = errors;
        access(1'b1, 12'h350, 4'hf, 32'h5a5a1234, firstStall);
        access(1'b0, 12'h750, 4'h0, '0, firstStall);
        access(1'b0, 12'h350, 4'h0, '0, firstStall);
        checkStall(firstStall, 1'b1, "evicted line");
        reportTest("conflict eviction", mark);

        // tags 0 to 3, all indices
        mark = errors;
        for (int i = 0; i < randomCount; i++) begin
            r = $random(seed);
            data = $random(seed);
            access(r[31], {2'b00, r[9:0]}, r[19:16], data, firstStall);
        end
        reportTest("random traffic", mark);

        // both or neither of read and write
        mark = errors;
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            request.read = r[0];
            request.write = r[0];
            // aimed at the words read back below
            case (i % 3)
                0: request.addr = 12'h124;
                1: request.addr = 12'h238;
                default: request.addr = 12'h350;
            endcase
            request.byteSelect = 4'hf;
            request.writeData = $random(seed);
            @(negedge clock);
            checkStall(stall, 1'b0, "non-request");
            @(posedge clock);
            #2;
        end
        dropRequest();
        access(1'b0, 12'h124, 4'h0, '0, firstStall);
        access(1'b0, 12'h238, 4'h0, '0, firstStall);
        access(1'b0, 12'h350, 4'h0, '0, firstStall);
        reportTest("non-requests", mark);

        $display("%0d tests, %0d checks, %0d errors", testCount, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+test
source/dcachePkg.sv
source/dcacheArray.sv
source/blockMemory.sv
source/dcacheController.sv
source/dataCache.sv
test/dataCacheTb.sv

//--- run.sh
#!/bin/sh
set -e

verilator --binary -f list.f --top-module dataCacheTb -o dataCacheSim
result=$(./obj_dir/dataCacheSim)
echo "$result"

if echo "$result" | grep -q "all tests passed"; then
    exit 0
fi
exit 1
